// File: rtl/arcade_pkg.sv
package arcade_pkg;

	// ====================
	// Widths
	// ====================

	localparam int STATUS_W   = 32;   // Menu status word from the service controller
	localparam int DL_ADDR_W  = 25;   // Default download address width
	localparam int CPU_ADDR_W = 15;   // Default CPU ROM address width

	// ====================
	// Menu options
	// ====================

	// Decoded status bits, one field per menu entry
	typedef struct packed {
		logic       rotate;     // 1 selects the normal control layout
		logic [1:0] scanlines;
		logic       blend;
		logic       units_km;
		logic       freeze;
		logic       zippy;      // Alternate game name
		logic       demo;
		logic       test;
	} options_t;

	// ====================
	// Controls
	// ====================

	// Held keyboard buttons
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic fire3;
		logic coin;
		logic start1;
		logic start2;
	} key_btn_t;

	// Player controls as the game core sees them
	typedef struct packed {
		logic accel;
		logic brake;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic start1;
		logic start2;
		logic coin;
	} ctrl_t;

	// One request on the 16 bit memory port
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          wdata;
		logic                 we;
		logic                 rd;
	} mem_req_t;

endpackage

// File: rtl/core_config_regs.sv
`timescale 1ns/1ns

module core_config_regs (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  logic [arcade_pkg::STATUS_W-1:0] status,
	input  logic                           status_wr,
	output arcade_pkg::options_t           opts,
	output logic [7:0]                     dip2,
	output logic                           reset_req
);

	logic [arcade_pkg::STATUS_W-1:0] status_q;

	// Last word written by the menu
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_q <= '0;
		end else if (status_wr) begin
			status_q <= status;
		end
	end

	// ====================
	// Video options
	// ====================

	// Scaler side settings, plus the control layout in control_mapper
	assign opts.rotate    = status_q[2];      // Normal layout when set
	assign opts.scanlines = status_q[4:3];
	assign opts.blend     = status_q[10];

	// ====================
	// Game options
	// ====================

	// These reach the game through the second DIP bank
	assign opts.units_km  = status_q[5];
	assign opts.freeze    = status_q[6];
	assign opts.zippy     = status_q[7];
	assign opts.demo      = status_q[8];
	assign opts.test      = status_q[9];

	// DIP switches are active low on the board
	// Low three bits fix coin mode, cocktail and flip
	assign dip2 = {
		~opts.test,
		~opts.demo,
		~opts.zippy,
		~opts.freeze,
		~opts.units_km,
		3'b110
	};

	// Menu reset entry or the controller's own reset bit
	assign reset_req = status_q[0] | status_q[1];

endmodule

// File: rtl/key_latch.sv
`timescale 1ns/1ns

module key_latch (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 key_strobe,
	input  logic                 key_pressed,
	input  logic [7:0]           key_code,
	output arcade_pkg::key_btn_t keys
);

	// ====================
	// Scancodes
	// ====================

	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_ESC   = 8'h76;   // Coin
	localparam logic [7:0] SC_F1    = 8'h05;   // One player start
	localparam logic [7:0] SC_F2    = 8'h06;   // Two player start
	localparam logic [7:0] SC_CTRL  = 8'h14;
	localparam logic [7:0] SC_ALT   = 8'h11;
	localparam logic [7:0] SC_SPACE = 8'h29;

	// Make and break events both arrive as strobes
	// key_pressed tells which one it was
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			keys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				SC_UP:    keys.up     <= key_pressed;
				SC_DOWN:  keys.down   <= key_pressed;
				SC_LEFT:  keys.left   <= key_pressed;
				SC_RIGHT: keys.right  <= key_pressed;
				SC_ESC:   keys.coin   <= key_pressed;
				SC_F1:    keys.start1 <= key_pressed;
				SC_F2:    keys.start2 <= key_pressed;
				SC_CTRL:  keys.fire3  <= key_pressed;
				SC_ALT:   keys.fire2  <= key_pressed;
				SC_SPACE: keys.fire1  <= key_pressed;
				default:  keys        <= keys;   // Unmapped key, hold all states
			endcase
		end
	end

endmodule

// File: rtl/control_mapper.sv
`timescale 1ns/1ns

module control_mapper (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  arcade_pkg::key_btn_t keys,
	input  logic [7:0]           joy0,
	input  logic [7:0]           joy1,
	input  logic                 rotate,
	output arcade_pkg::ctrl_t    ctrl
);

	logic [5:0]        joy_or;
	logic              m_up;
	logic              m_down;
	logic              m_left;
	logic              m_right;
	arcade_pkg::ctrl_t ctrl_d;

	// Both sticks drive the one player
	assign joy_or = joy0[5:0] | joy1[5:0];

	// Stick bits 0 right, 1 left, 2 down, 3 up
	assign m_up    = keys.up    | joy_or[3];
	assign m_down  = keys.down  | joy_or[2];
	assign m_left  = keys.left  | joy_or[1];
	assign m_right = keys.right | joy_or[0];

	// ====================
	// Rotation remap
	// ====================

	// With the screen turned, the stick is held sideways
	always_comb begin
		if (rotate) begin
			ctrl_d.accel = m_up;
			ctrl_d.brake = m_down;
			ctrl_d.left  = m_left;
			ctrl_d.right = m_right;
		end else begin
			ctrl_d.accel = m_left;
			ctrl_d.brake = m_right;
			ctrl_d.left  = m_down;
			ctrl_d.right = m_up;
		end
		ctrl_d.fire   = keys.fire1 | joy_or[4];
		ctrl_d.bomb   = keys.fire2 | joy_or[5];
		ctrl_d.start1 = keys.start1;   // Keyboard only
		ctrl_d.start2 = keys.start2;
		ctrl_d.coin   = keys.coin;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_d;
		end
	end

endmodule

// File: rtl/rom_loader.sv
`timescale 1ns/1ns

module rom_loader #(
	parameter int DL_ADDR_W  = arcade_pkg::DL_ADDR_W,
	parameter int CPU_ADDR_W = arcade_pkg::CPU_ADDR_W
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [7:0]           dl_data,
	input  logic [CPU_ADDR_W-1:0] cpu_rom_addr,
	input  logic                 cpu_rom_rd,
	input  logic                 reset_req,
	input  logic                 user_reset,
	output arcade_pkg::mem_req_t mem,
	output logic                 core_reset
);

	arcade_pkg::mem_req_t mem_d;
	logic [DL_ADDR_W-1:0] addr_q;
	logic [15:0]          wdata_q;
	logic                 we_q;
	logic                 rd_q;
	logic                 dl_active_q;
	logic                 loaded;

	// ====================
	// Port select
	// ====================

	// The download owns the port for its whole length
	always_comb begin
		mem_d.wdata = {dl_data, dl_data};   // Same byte to both lanes
		if (dl_active) begin
			mem_d.addr = dl_addr;
			mem_d.we   = dl_wr;
			mem_d.rd   = 1'b0;
		end else begin
			mem_d.addr = {{(DL_ADDR_W-CPU_ADDR_W){1'b0}}, cpu_rom_addr};
			mem_d.we   = 1'b0;
			mem_d.rd   = cpu_rom_rd;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q  <= mem_d.addr;
		wdata_q <= mem_d.wdata;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			we_q <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			we_q <= mem_d.we;
			rd_q <= mem_d.rd;
		end
	end

	assign mem = '{addr: addr_q, wdata: wdata_q, we: we_q, rd: rd_q};

	// ====================
	// Game reset
	// ====================

	// Loaded once the first download ends
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_q <= 1'b0;
			loaded      <= 1'b0;
			core_reset  <= 1'b1;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active_q && !dl_active) begin
				loaded <= 1'b1;
			end
			core_reset <= ~loaded | reset_req | user_reset;
		end
	end

endmodule

// File: rtl/arcade_host.sv
`timescale 1ns/1ns

module arcade_host #(
	parameter int DL_ADDR_W  = arcade_pkg::DL_ADDR_W,
	parameter int CPU_ADDR_W = arcade_pkg::CPU_ADDR_W
) (
	input  logic                            clk_sys,
	input  logic                            arst_n,
	input  logic [arcade_pkg::STATUS_W-1:0] status,
	input  logic                            status_wr,
	input  logic                            key_strobe,
	input  logic                            key_pressed,
	input  logic [7:0]                      key_code,
	input  logic [7:0]                      joy0,
	input  logic [7:0]                      joy1,
	input  logic                            user_reset,   // Board button
	input  logic                            dl_active,
	input  logic                            dl_wr,
	input  logic [DL_ADDR_W-1:0]            dl_addr,
	input  logic [7:0]                      dl_data,
	input  logic [CPU_ADDR_W-1:0]           cpu_rom_addr,
	input  logic                            cpu_rom_rd,
	output arcade_pkg::ctrl_t               ctrl,
	output arcade_pkg::options_t            opts,
	output logic [7:0]                      dip2,
	output arcade_pkg::mem_req_t            mem,
	output logic                            core_reset
);

	logic                 reset_req;
	arcade_pkg::key_btn_t keys;

	// ====================
	// Menu and input side
	// ====================

	core_config_regs u_config (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.status    (status),
		.status_wr (status_wr),
		.opts      (opts),
		.dip2      (dip2),
		.reset_req (reset_req)
	);

	key_latch u_keys (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.keys        (keys)
	);

	control_mapper u_mapper (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.keys    (keys),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (opts.rotate),
		.ctrl    (ctrl)
	);

	// ====================
	// Memory and reset
	// ====================

	rom_loader #(
		.DL_ADDR_W  (DL_ADDR_W),
		.CPU_ADDR_W (CPU_ADDR_W)
	) u_loader (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cpu_rom_addr (cpu_rom_addr),
		.cpu_rom_rd   (cpu_rom_rd),
		.reset_req    (reset_req),
		.user_reset   (user_reset),
		.mem          (mem),
		.core_reset   (core_reset)
	);

endmodule

// File: sim/tb_arcade_host.sv
`timescale 1ns/1ns

module tb_arcade_host;

	localparam int DL_ADDR_W    = arcade_pkg::DL_ADDR_W;
	localparam int CPU_ADDR_W   = arcade_pkg::CPU_ADDR_W;
	localparam int RESET_CYCLES = 16;

	logic                            clk_sys;
	logic                            arst_n;
	logic [arcade_pkg::STATUS_W-1:0] status;
	logic                            status_wr;
	logic                            key_strobe;
	logic                            key_pressed;
	logic [7:0]                      key_code;
	logic [7:0]                      joy0;
	logic [7:0]                      joy1;
	logic                            user_reset;
	logic                            dl_active;
	logic                            dl_wr;
	logic [DL_ADDR_W-1:0]            dl_addr;
	logic [7:0]                      dl_data;
	logic [CPU_ADDR_W-1:0]           cpu_rom_addr;
	logic                            cpu_rom_rd;
	arcade_pkg::ctrl_t               ctrl;
	arcade_pkg::options_t            opts;
	logic [7:0]                      dip2;
	arcade_pkg::mem_req_t            mem;
	logic                            core_reset;

	int value_errors;
	int other_failures;   // Timeouts and file trouble

	arcade_host #(.DL_ADDR_W(DL_ADDR_W), .CPU_ADDR_W(CPU_ADDR_W)) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;   // 4 ns period
	end

	// ====================
	// Helpers
	// ====================

	// Step past the next rising edge, where inputs change and outputs are read
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			value_errors++;
		end
	endtask

	task automatic wait_core_reset(input logic level, input int limit);
		int n;
		n = 0;
		while (core_reset !== level && n < limit) begin
			next_cycle();
			n++;
		end
		assert (core_reset === level) else begin
			$display("Timeout at %0t ns: core_reset did not go to %0b within %0d cycles",
				$time, level, limit);
			other_failures++;
		end
	endtask

	// One line of the cases file
	task automatic run_case(input logic [7:0] op, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] c);
		case (op)
			"S": begin
				status    = a;
				status_wr = 1'b1;
				next_cycle();
				status_wr = 1'b0;
				check_word("dip2", 32'(dip2), 32'(b[7:0]));
				check_word("opts", 32'(opts), 32'(c[8:0]));
			end
			"K": begin
				key_code    = a[7:0];
				key_pressed = b[0];
				key_strobe  = 1'b1;
				next_cycle();
				key_strobe = 1'b0;
				next_cycle();   // Key latch then control register
				check_word("ctrl after key", 32'(ctrl), 32'(c[8:0]));
			end
			"J": begin
				joy0 = a[7:0];
				joy1 = b[7:0];
				next_cycle();
				check_word("ctrl after joystick", 32'(ctrl), 32'(c[8:0]));
			end
			"D": begin
				dl_active = 1'b1;
				dl_wr     = c[0];
				dl_addr   = a[DL_ADDR_W-1:0];
				dl_data   = b[7:0];
				next_cycle();
				dl_wr = 1'b0;
				check_word("download addr", 32'(mem.addr), 32'(a[DL_ADDR_W-1:0]));
				check_word("download wdata", 32'(mem.wdata), 32'({b[7:0], b[7:0]}));
				check_word("download we", 32'(mem.we), 32'(c[0]));
				check_word("download rd", 32'(mem.rd), 32'd0);
				check_word("core_reset in download", 32'(core_reset), 32'd1);
			end
			"E": begin
				dl_active = 1'b0;
				dl_wr     = 1'b0;
				wait_core_reset(1'b0, int'(a));
			end
			"R": begin
				cpu_rom_addr = a[CPU_ADDR_W-1:0];
				cpu_rom_rd   = b[0];
				next_cycle();
				cpu_rom_rd = 1'b0;
				check_word("cpu addr", 32'(mem.addr), 32'(a[CPU_ADDR_W-1:0]));
				check_word("cpu we", 32'(mem.we), 32'd0);
				check_word("cpu rd", 32'(mem.rd), 32'(b[0]));
			end
			"C": begin
				user_reset = a[0];
				wait_core_reset(b[0], int'(c));
			end
			default: begin
				$display("Unknown operation %c in the cases file", op);
				other_failures++;
			end
		endcase
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		value_errors   = 0;
		other_failures = 0;
		arst_n       = 1'b0;
		status       = '0;
		status_wr    = 1'b0;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = '0;
		joy0         = '0;
		joy1         = '0;
		user_reset   = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cpu_rom_addr = '0;
		cpu_rom_rd   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1 arst_n = 1'b1;

		check_word("core_reset after reset", 32'(core_reset), 32'd1);
		check_word("ctrl after reset", 32'(ctrl), 32'd0);
		check_word("opts after reset", 32'(opts), 32'd0);
		check_word("mem we and rd after reset", 32'({mem.we, mem.rd}), 32'd0);
		check_word("dip2 after reset", 32'(dip2), 32'h0000_00FE);   // Every game switch off

		fd = $fopen("sim/arcade_host_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/arcade_host_cases.txt");
			other_failures++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h %h", op, a, b, c);
					if (n == 4) begin
						run_case(op, a, b, c);
					end
				end
			end
			$fclose(fd);
		end

		$display("Run finished with %0d value errors and %0d other failures",
			value_errors, other_failures);
		if (value_errors == 0 && other_failures == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: sim/arcade_host_cases.txt
# Columns are op a b c in hex and unused columns hold 0
# S status dip2 opts / K code pressed ctrl / J joy0 joy1 ctrl / D addr data we
# E limit / R addr rd / C user_reset core_reset limit
C 0 1 8
D 0000000 A5 1
D 1ABCDEF 7E 1
D 0000002 11 0
E 10 0 0
R 7FFF 1 0
R 0042 0 0
S 000006B4 56 1B5
S 00000148 AE 04A
S 00000002 FE 000
C 0 1 8
S 00000004 FE 100
C 0 0 8
C 1 1 8
C 0 0 8
K 75 1 100
K 33 1 100
K 75 0 000
K 29 1 010
K 29 0 000
J 08 00 100
J 01 00 020
S 00000000 FE 000
J 00 02 100
J 08 00 020
J 04 00 040
J 30 00 018

// File: arcade_host.f
rtl/arcade_pkg.sv
rtl/core_config_regs.sv
rtl/key_latch.sv
rtl/control_mapper.sv
rtl/rom_loader.sv
rtl/arcade_host.sv
sim/tb_arcade_host.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench from the project root, then scan the log
verilator --binary --timing --assert -f arcade_host.f --top-module tb_arcade_host \
	&& ./obj_dir/Vtb_arcade_host > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
